// File: design/sched_pkg.sv
package sched_pkg;

    //////////////////////////////
    // cell field widths
    //////////////////////////////

    // single-beat cell payload
    parameter int DATA_W = 64;
    // metadata, low bits carry the destination bitmap
    parameter int META_W = 16;
    // scheduling rank
    parameter int RANK_W = 18;
    // pifo info word
    parameter int PIFO_W = 32;

    // valid flag sits in the msb of the pifo word
    parameter int PIFO_VALID_BIT = 31;

    // input tuser = {pifo info, metadata}
    parameter int TUSER_W = PIFO_W + META_W;

    //////////////////////////////
    // field types
    //////////////////////////////

    typedef logic [DATA_W-1:0] cell_data_t;
    typedef logic [META_W-1:0] cell_meta_t;
    typedef logic [PIFO_W-1:0] pifo_info_t;
    typedef logic [RANK_W-1:0] rank_t;

    // rank given to cells without a valid pifo word
    // so they sort behind everything else
    parameter rank_t RANK_MAX = '1;

endpackage

// File: design/cell_if.sv
interface cell_if
    import sched_pkg::*;
#(
    parameter int NUM_PORTS = 4
)
();

    // registered cell, shared by all calendars
    cell_data_t           data;
    cell_meta_t           meta;
    pifo_info_t           pifo;
    // one insert strobe per port
    logic [NUM_PORTS-1:0] wr_en;

    // enqueue side
    modport agent
    (
        output data,
        output meta,
        output pifo,
        output wr_en
    );

    // per-port calendar side
    modport calendar
    (
        input data,
        input meta,
        input pifo,
        input wr_en
    );

endinterface

// File: design/enqueue_agent.sv
module enqueue_agent
    import sched_pkg::*;
#(
    parameter int NUM_PORTS = 4,
    localparam int DROP_W = 16
)
(
    input  logic                              axis_aclk,
    input  logic                              axis_resetn,

    input  cell_data_t                        s_axis_tdata,
    input  logic [TUSER_W-1:0]                s_axis_tuser,
    input  logic                              s_axis_tvalid,
    output logic                              s_axis_tready,

    input  logic [NUM_PORTS-1:0]              full,
    cell_if.agent                             cell_bus,

    output logic [NUM_PORTS-1:0][DROP_W-1:0]  drop_count
);

    //////////////////////////////
    // input register
    //////////////////////////////

    logic                 in_vld;
    cell_data_t           in_data;
    cell_meta_t           in_meta;
    pifo_info_t           in_pifo;
    // ports the registered cell is meant for
    logic [NUM_PORTS-1:0] addressed;

    // a cell is taken on every valid cycle
    always_ff @(posedge axis_aclk)
    begin
        if (!axis_resetn)
            in_vld <= 1'b0;
        else
            in_vld <= s_axis_tvalid;
    end

    // payload with tuser split into meta and pifo word
    always_ff @(posedge axis_aclk)
    begin
        in_data <= s_axis_tdata;
        in_meta <= s_axis_tuser[META_W-1:0];
        in_pifo <= s_axis_tuser[TUSER_W-1:META_W];
    end

    //////////////////////////////
    // destination decode
    //////////////////////////////

    assign addressed = {NUM_PORTS{in_vld}} & in_meta[NUM_PORTS-1:0];

    // write only where the calendar still has room
    assign cell_bus.wr_en = addressed & ~full;
    assign cell_bus.data  = in_data;
    assign cell_bus.meta  = in_meta;
    assign cell_bus.pifo  = in_pifo;

    // plain level that is low while any port is full
    assign s_axis_tready = ~|full;

    //////////////////////////////
    // per-port drop counters
    //////////////////////////////

    // wrap on overflow
    always_ff @(posedge axis_aclk)
    begin
        if (!axis_resetn)
        begin
            drop_count <= '0;
        end
        else
        begin
            for (int p = 0; p < NUM_PORTS; p++)
            begin
                // addressed but no space left
                if (addressed[p] && full[p])
                    drop_count[p] <= drop_count[p] + DROP_W'(1);
            end
        end
    end

    // an insert strobe must trace back to a valid input cell
    // that named this port one cycle earlier
    a_wr_en_in_bitmap: assert property (
        @(posedge axis_aclk) disable iff (!axis_resetn)
        (cell_bus.wr_en & ~$past({NUM_PORTS{s_axis_tvalid}} & s_axis_tuser[NUM_PORTS-1:0])) == '0
    );

endmodule

// File: design/pifo_calendar.sv
module pifo_calendar
    import sched_pkg::*;
#(
    parameter int PIFO_DEPTH = 8,
    parameter int PORT_IDX = 0,
    localparam int CNT_W = $clog2(PIFO_DEPTH + 1)
)
(
    input  logic              axis_aclk,
    input  logic              axis_resetn,

    cell_if.calendar          cell_bus,

    input  logic              pop,
    output cell_data_t        head_data,
    output cell_meta_t        head_meta,
    output pifo_info_t        head_pifo,
    output logic              empty,
    output logic              full,
    output logic [CNT_W-1:0]  q_size
);

    // invalid pifo word sorts last
    function automatic rank_t eff_rank(input pifo_info_t info);
        return info[PIFO_VALID_BIT] ? info[RANK_W-1:0] : RANK_MAX;
    endfunction

    //////////////////////////////
    // calendar storage
    //////////////////////////////

    // slot 0 is the head and slots 0..count-1 hold cells
    cell_data_t              cal_data [PIFO_DEPTH];
    cell_meta_t              cal_meta [PIFO_DEPTH];
    pifo_info_t              cal_pifo [PIFO_DEPTH];
    cell_data_t              nxt_data [PIFO_DEPTH];
    cell_meta_t              nxt_meta [PIFO_DEPTH];
    pifo_info_t              nxt_pifo [PIFO_DEPTH];
    logic [CNT_W-1:0]        count;
    logic                    ins;
    rank_t                   new_rank;
    // slot is free or holds a strictly larger rank
    logic [PIFO_DEPTH-1:0]   behind;

    assign ins      = cell_bus.wr_en[PORT_IDX];
    assign new_rank = eff_rank(cell_bus.pifo);

    // storage is sorted so behind is a thermometer code
    always_comb
    begin
        for (int i = 0; i < PIFO_DEPTH; i++)
            behind[i] = (i >= int'(count)) || (eff_rank(cal_pifo[i]) > new_rank);
    end

    //////////////////////////////
    // shift and insert
    //////////////////////////////

    always_comb
    begin
        int src;
        int prv;
        for (int i = 0; i < PIFO_DEPTH; i++)
        begin
            // old slot feeding new slot i is one higher on pop
            src = (pop && i < PIFO_DEPTH - 1) ? i + 1 : i;
            prv = (src > 0) ? src - 1 : 0;
            nxt_data[i] = cal_data[src];
            nxt_meta[i] = cal_meta[src];
            nxt_pifo[i] = cal_pifo[src];
            if (ins && behind[src])
            begin
                // first larger slot takes the new cell
                if (i == 0 || !behind[prv])
                begin
                    nxt_data[i] = cell_bus.data;
                    nxt_meta[i] = cell_bus.meta;
                    nxt_pifo[i] = cell_bus.pifo;
                end
                // rest move down one place
                else
                begin
                    nxt_data[i] = cal_data[prv];
                    nxt_meta[i] = cal_meta[prv];
                    nxt_pifo[i] = cal_pifo[prv];
                end
            end
        end
    end

    always_ff @(posedge axis_aclk)
    begin
        if (ins || pop)
        begin
            cal_data <= nxt_data;
            cal_meta <= nxt_meta;
            cal_pifo <= nxt_pifo;
        end
    end

    // occupancy where insert and pop may coincide
    always_ff @(posedge axis_aclk)
    begin
        if (!axis_resetn)
            count <= '0;
        else
            count <= count + CNT_W'(ins) - CNT_W'(pop);
    end

    assign head_data = cal_data[0];
    assign head_meta = cal_meta[0];
    assign head_pifo = cal_pifo[0];
    assign empty     = (count == '0);
    assign full      = (count == CNT_W'(PIFO_DEPTH));
    assign q_size    = count;

    // agent must hold off a full port
    a_no_insert_full: assert property (
        @(posedge axis_aclk) disable iff (!axis_resetn) ins |-> !full
    );

    // egress stage only pops a cell that exists
    a_no_pop_empty: assert property (
        @(posedge axis_aclk) disable iff (!axis_resetn) pop |-> !empty
    );

endmodule

// File: design/egress_stage.sv
module egress_stage
    import sched_pkg::*;
(
    input  logic        axis_aclk,
    input  logic        axis_resetn,

    input  cell_data_t  head_data,
    input  cell_meta_t  head_meta,
    input  pifo_info_t  head_pifo,
    input  logic        empty,
    output logic        pop,

    output cell_data_t  m_axis_tdata,
    output cell_meta_t  m_axis_tuser,
    output pifo_info_t  m_axis_tpifo,
    output logic        m_axis_tvalid,
    input  logic        m_axis_tready
);

    logic out_vld;

    // refill when the slot is free or being drained
    assign pop = !empty && (!out_vld || m_axis_tready);

    always_ff @(posedge axis_aclk)
    begin
        if (!axis_resetn)
            out_vld <= 1'b0;
        else if (pop)
            out_vld <= 1'b1;
        else if (m_axis_tready)
            out_vld <= 1'b0;
    end

    // output payload, loaded from the calendar head
    always_ff @(posedge axis_aclk)
    begin
        if (pop)
        begin
            m_axis_tdata <= head_data;
            m_axis_tuser <= head_meta;
            m_axis_tpifo <= head_pifo;
        end
    end

    assign m_axis_tvalid = out_vld;

    // back-pressure holds the beat still
    a_hold_stable: assert property (
        @(posedge axis_aclk) disable iff (!axis_resetn)
        (m_axis_tvalid && !m_axis_tready) |=>
            (m_axis_tvalid && $stable(m_axis_tdata) && $stable(m_axis_tuser)
             && $stable(m_axis_tpifo))
    );

endmodule

// File: design/pifo_scheduler_top.sv
module pifo_scheduler_top
    import sched_pkg::*;
#(
    parameter int NUM_PORTS = 4,
    parameter int PIFO_DEPTH = 8,
    localparam int CNT_W = $clog2(PIFO_DEPTH + 1)
)
(
    input  logic                          axis_aclk,
    input  logic                          axis_resetn,

    input  cell_data_t                    s_axis_tdata,
    input  logic [TUSER_W-1:0]            s_axis_tuser,
    input  logic                          s_axis_tvalid,
    output logic                          s_axis_tready,

    output logic [NUM_PORTS*DATA_W-1:0]   m_axis_tdata,
    output logic [NUM_PORTS*META_W-1:0]   m_axis_tuser,
    output logic [NUM_PORTS*PIFO_W-1:0]   m_axis_tpifo,
    output logic [NUM_PORTS-1:0]          m_axis_tvalid,
    input  logic [NUM_PORTS-1:0]          m_axis_tready,

    output logic [NUM_PORTS*CNT_W-1:0]    q_size,
    output logic [NUM_PORTS*16-1:0]       drop_count
);

    // per-port full flags back to the agent
    logic [NUM_PORTS-1:0] full;

    cell_if #(.NUM_PORTS(NUM_PORTS)) cell_bus ();

    enqueue_agent #(.NUM_PORTS(NUM_PORTS)) u_agent
    (
        .axis_aclk     (axis_aclk),
        .axis_resetn   (axis_resetn),
        .s_axis_tdata  (s_axis_tdata),
        .s_axis_tuser  (s_axis_tuser),
        .s_axis_tvalid (s_axis_tvalid),
        .s_axis_tready (s_axis_tready),
        .full          (full),
        .cell_bus      (cell_bus),
        .drop_count    (drop_count)
    );

    //////////////////////////////
    // one calendar + egress per port
    //////////////////////////////

    for (genvar p = 0; p < NUM_PORTS; p++)
    begin : gen_port
        cell_data_t head_data;
        cell_meta_t head_meta;
        pifo_info_t head_pifo;
        logic       empty;
        logic       pop;

        pifo_calendar #(.PIFO_DEPTH(PIFO_DEPTH), .PORT_IDX(p)) u_calendar
        (
            .axis_aclk   (axis_aclk),
            .axis_resetn (axis_resetn),
            .cell_bus    (cell_bus),
            .pop         (pop),
            .head_data   (head_data),
            .head_meta   (head_meta),
            .head_pifo   (head_pifo),
            .empty       (empty),
            .full        (full[p]),
            .q_size      (q_size[p*CNT_W +: CNT_W])
        );

        egress_stage u_egress
        (
            .axis_aclk     (axis_aclk),
            .axis_resetn   (axis_resetn),
            .head_data     (head_data),
            .head_meta     (head_meta),
            .head_pifo     (head_pifo),
            .empty         (empty),
            .pop           (pop),
            .m_axis_tdata  (m_axis_tdata[p*DATA_W +: DATA_W]),
            .m_axis_tuser  (m_axis_tuser[p*META_W +: META_W]),
            .m_axis_tpifo  (m_axis_tpifo[p*PIFO_W +: PIFO_W]),
            .m_axis_tvalid (m_axis_tvalid[p]),
            .m_axis_tready (m_axis_tready[p])
        );
    end

endmodule

// File: sim/tb_pifo_scheduler.sv
module tb_pifo_scheduler
    import sched_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_PORTS  = 4;
    localparam int PIFO_DEPTH = 8;
    localparam int CNT_W      = $clog2(PIFO_DEPTH + 1);
    localparam int MAX_CYCLES = 2000;

    logic                            axis_aclk;
    logic                            axis_resetn;
    cell_data_t                      s_axis_tdata;
    logic [TUSER_W-1:0]              s_axis_tuser;
    logic                            s_axis_tvalid;
    logic                            s_axis_tready;
    logic [NUM_PORTS*DATA_W-1:0]     m_axis_tdata;
    logic [NUM_PORTS*META_W-1:0]     m_axis_tuser;
    logic [NUM_PORTS*PIFO_W-1:0]     m_axis_tpifo;
    logic [NUM_PORTS-1:0]            m_axis_tvalid;
    logic [NUM_PORTS-1:0]            m_axis_tready;
    logic [NUM_PORTS*CNT_W-1:0]      q_size;
    logic [NUM_PORTS*16-1:0]         drop_count;

    int seed = 5650;
    int errors = 0;
    int checks = 0;
    int tests_passed = 0;
    int tests_failed = 0;
    int cycle_count = 0;

    // cells of the burst being sent, and their expected leaving order
    cell_data_t burst_data [16];
    cell_meta_t burst_meta [16];
    pifo_info_t burst_pifo [16];
    int         order [16];

    // scoreboard, one entry per expected output beat
    int         exp_port [$];
    cell_data_t exp_data [$];
    cell_meta_t exp_meta [$];
    pifo_info_t exp_pifo [$];

    pifo_scheduler_top #(.NUM_PORTS(NUM_PORTS), .PIFO_DEPTH(PIFO_DEPTH)) UUT
    (
        .axis_aclk     (axis_aclk),
        .axis_resetn   (axis_resetn),
        .s_axis_tdata  (s_axis_tdata),
        .s_axis_tuser  (s_axis_tuser),
        .s_axis_tvalid (s_axis_tvalid),
        .s_axis_tready (s_axis_tready),
        .m_axis_tdata  (m_axis_tdata),
        .m_axis_tuser  (m_axis_tuser),
        .m_axis_tpifo  (m_axis_tpifo),
        .m_axis_tvalid (m_axis_tvalid),
        .m_axis_tready (m_axis_tready),
        .q_size        (q_size),
        .drop_count    (drop_count)
    );

    always #5 axis_aclk = ~axis_aclk;

    //////////////////////////////
    // reference model
    //////////////////////////////

    // cleared valid bit counts as the largest rank
    function automatic logic [17:0] ref_rank(input logic [31:0] info);
        return info[31] ? info[17:0] : 18'h3ffff;
    endfunction

    // cell 0 finds the port idle and leaves first
    // rest by rank, ties keep arrival order
    function automatic void build_order(input int n);
        bit taken [16];
        int best;
        for (int i = 0; i < 16; i++)
            taken[i] = 1'b0;
        order[0] = 0;
        taken[0] = 1'b1;
        for (int k = 1; k < n; k++)
        begin
            best = -1;
            for (int i = 1; i < n; i++)
            begin
                if (!taken[i] && (best < 0 || ref_rank(burst_pifo[i]) < ref_rank(burst_pifo[best])))
                    best = i;
            end
            order[k] = best;
            taken[best] = 1'b1;
        end
    endfunction

    //////////////////////////////
    // stimulus helpers
    //////////////////////////////

    // random payload, small ranks so ties happen
    task automatic fill_burst(input int n, input logic [3:0] bitmap, input bit mix_invalid);
        logic [2:0] r3;
        logic       vbit;
        for (int i = 0; i < n; i++)
        begin
            burst_data[i] = {$random(seed), $random(seed)};
            burst_meta[i] = {12'($random(seed)), bitmap};
            r3 = 3'($random(seed));
            vbit = (mix_invalid && (i % 3 == 2)) ? 1'b0 : 1'b1;
            burst_pifo[i] = {vbit, 28'h0, r3};
        end
    endtask

    task automatic push_expected(input int port, input int n_keep);
        build_order(n_keep);
        for (int k = 0; k < n_keep; k++)
        begin
            exp_port.push_back(port);
            exp_data.push_back(burst_data[order[k]]);
            exp_meta.push_back(burst_meta[order[k]]);
            exp_pifo.push_back(burst_pifo[order[k]]);
        end
    endtask

    // back to back, returns on the edge that samples the last cell
    task automatic send_burst(input int n);
        for (int i = 0; i < n; i++)
        begin
            @(posedge axis_aclk);
            s_axis_tdata  <= burst_data[i];
            s_axis_tuser  <= {burst_pifo[i], burst_meta[i]};
            s_axis_tvalid <= 1'b1;
        end
        @(posedge axis_aclk);
        s_axis_tvalid <= 1'b0;
    endtask

    // a few spare cycles catch stray beats
    task automatic wait_drained();
        while (exp_port.size() != 0)
            @(negedge axis_aclk);
        repeat (4) @(posedge axis_aclk);
    endtask

    task automatic check_equal(input string name, input logic [63:0] exp_v,
                               input logic [63:0] got_v);
        checks++;
        assert (got_v == exp_v)
        else
        begin
            $display("FAIL %0t %s expected %h got %h", $time, name, exp_v, got_v);
            errors++;
        end
    endtask

    task automatic finish_test(input string name, input int err_before);
        if (errors == err_before)
        begin
            $display("test %s: ok", name);
            tests_passed++;
        end
        else
        begin
            $display("test %s: %0d errors", name, errors - err_before);
            tests_failed++;
        end
    endtask

    //////////////////////////////
    // output compare
    //////////////////////////////

    // each accepted beat must match the oldest entry for its port
    always @(posedge axis_aclk)
    begin
        int hit;
        if (axis_resetn)
        begin
            for (int p = 0; p < NUM_PORTS; p++)
            begin
                if (m_axis_tvalid[p] && m_axis_tready[p])
                begin
                    hit = -1;
                    for (int i = 0; i < exp_port.size(); i++)
                    begin
                        if (hit < 0 && exp_port[i] == p)
                            hit = i;
                    end
                    assert (hit >= 0)
                    else
                    begin
                        $display("port %0d sent a cell that was not expected at %0t", p, $time);
                        errors++;
                    end
                    if (hit >= 0)
                    begin
                        check_equal($sformatf("m_axis_tdata[%0d]", p), exp_data[hit],
                                    m_axis_tdata[p*DATA_W +: DATA_W]);
                        check_equal($sformatf("m_axis_tuser[%0d]", p), 64'(exp_meta[hit]),
                                    64'(m_axis_tuser[p*META_W +: META_W]));
                        check_equal($sformatf("m_axis_tpifo[%0d]", p), 64'(exp_pifo[hit]),
                                    64'(m_axis_tpifo[p*PIFO_W +: PIFO_W]));
                        exp_port.delete(hit);
                        exp_data.delete(hit);
                        exp_meta.delete(hit);
                        exp_pifo.delete(hit);
                    end
                end
            end
        end
    end

    // run limit
    initial
    begin
        while (cycle_count < MAX_CYCLES)
        begin
            @(posedge axis_aclk);
            cycle_count++;
        end
        $display("timeout, the tests did not finish within %0d cycles", MAX_CYCLES);
        $display("Something failed");
        $finish;
    end

    //////////////////////////////
    // test sequence
    //////////////////////////////

    initial
    begin
        int err0;
        axis_aclk     = 1'b0;
        axis_resetn   = 1'b0;
        s_axis_tdata  = '0;
        s_axis_tuser  = '0;
        s_axis_tvalid = 1'b0;
        m_axis_tready = '1;
        repeat (5) @(posedge axis_aclk);
        axis_resetn <= 1'b1;

        // idle state after reset
        err0 = errors;
        @(negedge axis_aclk);
        check_equal("m_axis_tvalid", 64'(0), 64'(m_axis_tvalid));
        check_equal("q_size", 64'(0), 64'(q_size));
        check_equal("drop_count", 64'(0), drop_count);
        check_equal("s_axis_tready", 64'(1), 64'(s_axis_tready));
        finish_test("reset", err0);

        // single cell to port 1, fixed latency
        err0 = errors;
        fill_burst(1, 4'b0010, 1'b0);
        push_expected(1, 1);
        send_burst(1);
        @(posedge axis_aclk);
        @(negedge axis_aclk);
        check_equal("m_axis_tvalid", 64'(0), 64'(m_axis_tvalid));
        @(posedge axis_aclk);
        @(negedge axis_aclk);
        check_equal("m_axis_tvalid", 64'(4'b0010), 64'(m_axis_tvalid));
        check_equal("m_axis_tdata[1]", burst_data[0], m_axis_tdata[DATA_W +: DATA_W]);
        check_equal("m_axis_tuser[1]", 64'(burst_meta[0]), 64'(m_axis_tuser[META_W +: META_W]));
        check_equal("m_axis_tpifo[1]", 64'(burst_pifo[0]), 64'(m_axis_tpifo[PIFO_W +: PIFO_W]));
        wait_drained();
        finish_test("latency", err0);

        // one cell, three destinations
        err0 = errors;
        fill_burst(1, 4'b1011, 1'b0);
        push_expected(0, 1);
        push_expected(1, 1);
        push_expected(3, 1);
        send_burst(1);
        wait_drained();
        finish_test("multicast", err0);

        // seven cells held back on port 2, some without a valid pifo word
        err0 = errors;
        m_axis_tready[2] <= 1'b0;
        fill_burst(7, 4'b0100, 1'b1);
        push_expected(2, 7);
        send_burst(7);
        while (!(m_axis_tvalid[2] && q_size[2*CNT_W +: CNT_W] == CNT_W'(6)))
            @(negedge axis_aclk);
        @(posedge axis_aclk);
        m_axis_tready[2] <= 1'b1;
        wait_drained();
        finish_test("rank order", err0);

        // 1 in egress + 8 in calendar, last three dropped
        err0 = errors;
        m_axis_tready[0] <= 1'b0;
        fill_burst(12, 4'b0001, 1'b0);
        push_expected(0, 9);
        send_burst(12);
        repeat (2) @(posedge axis_aclk);
        @(negedge axis_aclk);
        check_equal("q_size[0]", 64'(8), 64'(q_size[0 +: CNT_W]));
        check_equal("s_axis_tready", 64'(0), 64'(s_axis_tready));
        check_equal("drop_count[0]", 64'(3), 64'(drop_count[0 +: 16]));
        check_equal("drop_count[3:1]", 64'(0), 64'(drop_count[16 +: 48]));
        @(posedge axis_aclk);
        m_axis_tready[0] <= 1'b1;
        wait_drained();
        check_equal("s_axis_tready", 64'(1), 64'(s_axis_tready));
        check_equal("q_size", 64'(0), 64'(q_size));
        finish_test("overflow", err0);

        $display("tests passed %0d, failed %0d, checks %0d, errors %0d",
                 tests_passed, tests_failed, checks, errors);
        if (errors == 0 && tests_failed == 0)
            $display("Everything OK");
        else
            $display("Something failed");
        $finish;
    end

endmodule

// File: flist.f
design/sched_pkg.sv
design/cell_if.sv
design/enqueue_agent.sv
design/pifo_calendar.sv
design/egress_stage.sv
design/pifo_scheduler_top.sv
sim/tb_pifo_scheduler.sv

// File: run_sim.sh
#!/bin/sh
# build and run the testbench with Verilator
# status is nonzero unless the run reports success
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -j 0 \
    --top-module tb_pifo_scheduler -f flist.f &&
    ./obj_dir/Vtb_pifo_scheduler | tee /dev/stderr | grep -q "Everything OK" &&
    echo "simulation passed" ||
    { echo "simulation failed"; exit 1; }
